// ==== mmio_tlp_pkg.sv ====
// Wire formats for the completion path. The header is a flat 96-bit view, not the DW-swapped PCIe byte order
package mmio_tlp_pkg;

    // Format/type code for a completion that carries data
    localparam logic [7:0] PCIE_FMTTYPE_CPLD = 8'h4a;

    // Each TX lane carries half of the widest response
    localparam int LANE_PAYLOAD_BITS = 256;

    // Number of lanes in one TX beat
    localparam int TX_LANES = 2;

    // Completion header, padded out to three dwords
    typedef struct packed {
        logic [18:0] reserved;
        logic [7:0]  fmttype;
        // Length is counted in dwords
        logic [9:0]  length;
        logic [15:0] completer_id;
        logic [11:0] byte_count;
        logic [15:0] requester_id;
        logic [7:0]  tag;
        logic [6:0]  lower_addr;
    } t_cpl_hdr;

    // One lane of a TX beat
    // Only lane 0 ever carries a header, lane 1 leaves hdr at zero
    typedef struct packed {
        logic                         valid;
        logic                         sop;
        logic                         eop;
        t_cpl_hdr                     hdr;
        logic [LANE_PAYLOAD_BITS-1:0] payload;
    } t_tx_lane;

    // A full beat, lane 0 in the low index
    typedef t_tx_lane [TX_LANES-1:0] t_tx_beat;

endpackage

// ==== mmio_gen_pkg.sv ====
// MMIO request path types. Byte counts are assumed to be multiples of 4 and never above 64
package mmio_gen_pkg;

    // Width of the PCIe function number carried with each request
    localparam int FUNC_BITS = 2;

    // Width of the host read tag
    localparam int TAG_BITS = 5;

    // The accelerator always returns the widest possible response
    localparam int RSP_PAYLOAD_BITS = 512;

    typedef logic [FUNC_BITS-1:0] t_func;
    typedef logic [TAG_BITS-1:0]  t_tag;

    // Host read request, as seen by the completion logic
    // Only the fields needed to rebuild the completion header are kept
    typedef struct packed {
        t_func       func;
        t_tag        tag;
        logic [15:0] requester_id;
        logic [6:0]  lower_addr;
        // Always a multiple of 4, at most 64
        logic [11:0] byte_count;
    } t_mmio_host_req;

    // Accelerator read data for one earlier request
    // Short reads use only the low half of the payload
    typedef struct packed {
        t_func                       func;
        t_tag                        tag;
        logic [RSP_PAYLOAD_BITS-1:0] payload;
    } t_mmio_afu_rsp;

endpackage

// ==== mmio_func_steer.sv ====
// Requests are always accepted, so a request tag must not be reused while still outstanding
`timescale 1ns/1ps

module mmio_func_steer
    import mmio_gen_pkg::*;
#(
    parameter int NUM_FUNCS = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic                 host_req_valid,
    input  t_mmio_host_req       host_req,

    input  logic                 afu_rsp_valid,
    input  t_mmio_afu_rsp        afu_rsp,
    output logic                 afu_rsp_ready,

    output logic [NUM_FUNCS-1:0] req_wen,
    output t_mmio_host_req       req_q,

    output logic [NUM_FUNCS-1:0] rsp_valid,
    output t_mmio_afu_rsp        rsp,
    input  logic [NUM_FUNCS-1:0] rsp_ready
);

    logic req_valid_q;

    // Host requests take one register stage before reaching the tag tables
    always_ff @(posedge clk)
    begin
        req_valid_q <= host_req_valid;
        req_q <= host_req;

        if (!reset_n)
        begin
            req_valid_q <= 1'b0;
        end
    end

    // Decode the registered function into a one-hot table write strobe
    always_comb
    begin
        for (int f = 0; f < NUM_FUNCS; f++)
        begin
            req_wen[f] = req_valid_q && (req_q.func == FUNC_BITS'(f));
        end
    end

    // The response word fans out to every channel, only valid is steered
    assign rsp = afu_rsp;

    always_comb
    begin
        afu_rsp_ready = 1'b0;
        for (int f = 0; f < NUM_FUNCS; f++)
        begin
            rsp_valid[f] = afu_rsp_valid && (afu_rsp.func == FUNC_BITS'(f));
            // Only the addressed channel decides whether the response moves
            if (afu_rsp.func == FUNC_BITS'(f))
            begin
                afu_rsp_ready = rsp_ready[f];
            end
        end
    end

endmodule

// ==== mmio_cpl_chan.sv ====
// One function's completion channel; a response may arrive no earlier than 2 cycles after its request
`timescale 1ns/1ps

module mmio_cpl_chan
    import mmio_tlp_pkg::*;
    import mmio_gen_pkg::*;
#(
    parameter int FUNC_NUM = 0,
    parameter int MAX_TAGS = 32
)
(
    input  logic           clk,
    input  logic           reset_n,

    input  logic           req_wen,
    input  t_mmio_host_req req_q,

    input  logic           rsp_valid,
    input  t_mmio_afu_rsp  rsp,
    output logic           rsp_ready,

    output logic           chan_valid,
    output t_tx_beat       chan_beat,
    input  logic           chan_ready
);

    // A response travels through the FIFO with its original request beside it
    typedef struct packed {
        t_mmio_afu_rsp  rsp;
        t_mmio_host_req meta;
    } t_fifo_entry;

    // Outstanding request details, indexed by tag
    t_mmio_host_req tag_table [MAX_TAGS];
    t_mmio_host_req rsp_meta;

    always_ff @(posedge clk)
    begin
        if (req_wen)
        begin
            tag_table[req_q.tag] <= req_q;
        end
    end

    // The table is read as the response arrives
    // A write in the same cycle is for a different tag
    assign rsp_meta = tag_table[rsp.tag];

    // Two-entry response FIFO
    t_fifo_entry fifo_mem [2];
    logic        wr_ptr;
    logic        rd_ptr;
    logic [1:0]  fifo_count;
    logic        fifo_enq;
    logic        fifo_deq;
    logic        fifo_not_empty;
    t_fifo_entry fifo_head;

    assign rsp_ready = (fifo_count != 2'd2);
    assign fifo_not_empty = (fifo_count != 2'd0);
    assign fifo_enq = rsp_valid && rsp_ready;
    assign fifo_head = fifo_mem[rd_ptr];

    // Pop whenever the output register can take a new beat
    assign fifo_deq = fifo_not_empty && (!chan_valid || chan_ready);

    always_ff @(posedge clk)
    begin
        if (fifo_enq)
        begin
            fifo_mem[wr_ptr] <= '{rsp: rsp, meta: rsp_meta};
        end
    end

    always_ff @(posedge clk)
    begin
        if (fifo_enq)
        begin
            wr_ptr <= !wr_ptr;
        end
        if (fifo_deq)
        begin
            rd_ptr <= !rd_ptr;
        end
        // Push and pop together leave the count unchanged
        if (fifo_enq && !fifo_deq)
        begin
            fifo_count <= fifo_count + 2'd1;
        end
        else if (!fifo_enq && fifo_deq)
        begin
            fifo_count <= fifo_count - 2'd1;
        end

        if (!reset_n)
        begin
            wr_ptr <= 1'b0;
            rd_ptr <= 1'b0;
            fifo_count <= 2'd0;
        end
    end

    // Completion header for the FIFO head
    t_cpl_hdr cpl_hdr;
    logic     dual_lane;
    t_tx_beat beat_d;

    always_comb
    begin
        cpl_hdr = '0;
        cpl_hdr.fmttype = PCIE_FMTTYPE_CPLD;
        // Byte count is dword aligned, so the length is just a shift
        cpl_hdr.length = fifo_head.meta.byte_count[11:2];
        cpl_hdr.completer_id = 16'(FUNC_NUM);
        cpl_hdr.byte_count = fifo_head.meta.byte_count;
        cpl_hdr.requester_id = fifo_head.meta.requester_id;
        cpl_hdr.lower_addr = fifo_head.meta.lower_addr;
        // The tag comes from the response itself and not from the table
        cpl_hdr.tag = 8'(fifo_head.rsp.tag);
    end

    // Anything above 32 bytes spills into lane 1
    assign dual_lane = (fifo_head.meta.byte_count > 12'd32);

    always_comb
    begin
        beat_d = '0;
        beat_d[0].valid = fifo_not_empty;
        beat_d[0].sop = fifo_not_empty;
        beat_d[0].eop = fifo_not_empty && !dual_lane;
        beat_d[0].hdr = cpl_hdr;
        beat_d[0].payload = fifo_head.rsp.payload[LANE_PAYLOAD_BITS-1:0];
        beat_d[1].valid = fifo_not_empty && dual_lane;
        beat_d[1].eop = fifo_not_empty && dual_lane;
        beat_d[1].payload = fifo_head.rsp.payload[2*LANE_PAYLOAD_BITS-1:LANE_PAYLOAD_BITS];
    end

    // Output register, held until the arbiter grants it
    always_ff @(posedge clk)
    begin
        if (!chan_valid || chan_ready)
        begin
            chan_valid <= fifo_not_empty;
            chan_beat <= beat_d;
        end

        if (!reset_n)
        begin
            chan_valid <= 1'b0;
        end
    end

endmodule

// ==== mmio_tx_arb.sv ====
// Round-robin merge of the channel outputs; a channel's ready is combinational from the TX side
`timescale 1ns/1ps

module mmio_tx_arb
    import mmio_tlp_pkg::*;
#(
    parameter int NUM_FUNCS = 4
)
(
    input  logic                 clk,
    input  logic                 reset_n,

    input  logic [NUM_FUNCS-1:0] chan_valid,
    input  t_tx_beat             chan_beat [NUM_FUNCS],
    output logic [NUM_FUNCS-1:0] chan_ready,

    output logic                 tx_valid,
    output t_tx_beat             tx_beat,
    input  logic                 tx_ready
);

    // A single channel still needs a one-bit pointer
    localparam int PTR_BITS = (NUM_FUNCS > 1) ? $clog2(NUM_FUNCS) : 1;

    logic [PTR_BITS-1:0] prio_ptr;
    logic [PTR_BITS-1:0] winner;
    logic                found;
    logic                load;

    // The output register takes a new beat when empty or draining
    assign load = !tx_valid || tx_ready;

    // Search from the priority pointer upward, wrapping at NUM_FUNCS
    always_comb
    begin
        int idx;

        found = 1'b0;
        winner = '0;
        for (int i = 0; i < NUM_FUNCS; i++)
        begin
            idx = (int'(prio_ptr) + i) % NUM_FUNCS;
            if (!found && chan_valid[idx])
            begin
                found = 1'b1;
                winner = PTR_BITS'(idx);
            end
        end
    end

    // Grant is one-hot and only given when the beat can move
    always_comb
    begin
        for (int f = 0; f < NUM_FUNCS; f++)
        begin
            chan_ready[f] = load && found && (winner == PTR_BITS'(f));
        end
    end

    always_ff @(posedge clk)
    begin
        if (load)
        begin
            tx_valid <= found;
            if (found)
            begin
                tx_beat <= chan_beat[winner];
                // The winner drops to lowest priority on the next pick
                prio_ptr <= (winner == PTR_BITS'(NUM_FUNCS - 1)) ? '0 : winner + 1'b1;
            end
        end

        if (!reset_n)
        begin
            tx_valid <= 1'b0;
            prio_ptr <= '0;
        end
    end

endmodule

// ==== mmio_cpl_top.sv ====
// MMIO read completion top; MAX_TAGS must not exceed 2**TAG_BITS and NUM_FUNCS must not exceed 2**FUNC_BITS
`timescale 1ns/1ps

module mmio_cpl_top
    import mmio_tlp_pkg::*;
    import mmio_gen_pkg::*;
#(
    parameter int NUM_FUNCS = 4,
    parameter int MAX_TAGS = 32
)
(
    input  logic           clk,
    input  logic           reset_n,

    input  logic           host_req_valid,
    input  t_mmio_host_req host_req,

    input  logic           afu_rsp_valid,
    input  t_mmio_afu_rsp  afu_rsp,
    output logic           afu_rsp_ready,

    output logic           tx_valid,
    output t_tx_beat       tx_beat,
    input  logic           tx_ready
);

    logic [NUM_FUNCS-1:0] req_wen;
    t_mmio_host_req       req_q;
    logic [NUM_FUNCS-1:0] rsp_valid;
    t_mmio_afu_rsp        rsp;
    logic [NUM_FUNCS-1:0] rsp_ready;

    logic [NUM_FUNCS-1:0] chan_valid;
    t_tx_beat             chan_beat [NUM_FUNCS];
    logic [NUM_FUNCS-1:0] chan_ready;

    // Splits the request and response streams by function
    mmio_func_steer #(
        .NUM_FUNCS (NUM_FUNCS)
    ) steer_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .host_req_valid (host_req_valid),
        .host_req       (host_req),
        .afu_rsp_valid  (afu_rsp_valid),
        .afu_rsp        (afu_rsp),
        .afu_rsp_ready  (afu_rsp_ready),
        .req_wen        (req_wen),
        .req_q          (req_q),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .rsp_ready      (rsp_ready)
    );

    // One completion channel per function, each knows its own number
    for (genvar g = 0; g < NUM_FUNCS; g++)
    begin : g_chan
        mmio_cpl_chan #(
            .FUNC_NUM (g),
            .MAX_TAGS (MAX_TAGS)
        ) chan_i (
            .clk        (clk),
            .reset_n    (reset_n),
            .req_wen    (req_wen[g]),
            .req_q      (req_q),
            .rsp_valid  (rsp_valid[g]),
            .rsp        (rsp),
            .rsp_ready  (rsp_ready[g]),
            .chan_valid (chan_valid[g]),
            .chan_beat  (chan_beat[g]),
            .chan_ready (chan_ready[g])
        );
    end

    mmio_tx_arb #(
        .NUM_FUNCS (NUM_FUNCS)
    ) arb_i (
        .clk        (clk),
        .reset_n    (reset_n),
        .chan_valid (chan_valid),
        .chan_beat  (chan_beat),
        .chan_ready (chan_ready),
        .tx_valid   (tx_valid),
        .tx_beat    (tx_beat),
        .tx_ready   (tx_ready)
    );

endmodule

// ==== mmio_cpl_checker.sv ====
// Protocol rules on the completion top ports; the failure count is the only state it exposes
`timescale 1ns/1ps

module mmio_cpl_checker
    import mmio_tlp_pkg::*;
    import mmio_gen_pkg::*;
(
    input logic          clk,
    input logic          reset_n,
    input logic          afu_rsp_valid,
    input t_mmio_afu_rsp afu_rsp,
    input logic          afu_rsp_ready,
    input logic          tx_valid,
    input t_tx_beat      tx_beat,
    input logic          tx_ready
);

    // Number of assertion failures so far
    int unsigned error_count = 0;

    // The TX register is cleared by reset and stays clear one cycle past it
    a_reset_idle: assert property (@(posedge clk) !reset_n |=> !tx_valid)
    else
    begin
        error_count++;
        $error("tx_valid was high during reset or in the cycle after it");
    end

    // A stalled beat must not change until the sink takes it
    a_tx_hold: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && !tx_ready |=> tx_valid && $stable(tx_beat))
    else
    begin
        error_count++;
        $error("tx_beat changed or dropped while tx_ready was low");
    end

    // Every completion starts in lane 0
    a_lane0_sop: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && tx_beat[0].valid |-> tx_beat[0].sop)
    else
    begin
        error_count++;
        $error("Valid lane 0 without sop");
    end

    // Lane 1 only continues a packet that lane 0 did not end
    a_lane1_cont: assert property (@(posedge clk) disable iff (!reset_n)
        tx_valid && tx_beat[1].valid |-> !tx_beat[0].eop)
    else
    begin
        error_count++;
        $error("Lane 1 was valid although lane 0 carried eop");
    end

    // The response source has to hold its word while it is stalled
    a_rsp_hold: assert property (@(posedge clk) disable iff (!reset_n)
        afu_rsp_valid && !afu_rsp_ready |=> afu_rsp_valid && $stable(afu_rsp))
    else
    begin
        error_count++;
        $error("Accelerator response changed or dropped while stalled");
    end

    // All FIFOs are empty right after reset, so the response port is open
    a_rsp_open: assert property (@(posedge clk) $rose(reset_n) |-> afu_rsp_ready)
    else
    begin
        error_count++;
        $error("afu_rsp_ready was low right after reset");
    end

endmodule

bind mmio_cpl_top mmio_cpl_checker checker_i (
    .clk           (clk),
    .reset_n       (reset_n),
    .afu_rsp_valid (afu_rsp_valid),
    .afu_rsp       (afu_rsp),
    .afu_rsp_ready (afu_rsp_ready),
    .tx_valid      (tx_valid),
    .tx_beat       (tx_beat),
    .tx_ready      (tx_ready)
);

// ==== tb_mmio_cpl.sv ====
// Runs with NUM_FUNCS 4 and MAX_TAGS 32 and needs immediate and concurrent assertions enabled
`timescale 1ns/1ps

module tb_mmio_cpl
    import mmio_tlp_pkg::*;
    import mmio_gen_pkg::*;
();

    localparam int NUM_FUNCS = 4;
    localparam int MAX_TAGS = 32;
    localparam int TIMEOUT = 400;
    localparam int SEED = 32'h35e32c78;

    // What one accepted response must turn into on the TX side
    typedef struct packed {
        t_mmio_host_req              req;
        logic [RSP_PAYLOAD_BITS-1:0] payload;
    } t_expect;

    logic           clk = 1'b0;
    logic           reset_n = 1'b0;
    logic           host_req_valid = 1'b0;
    t_mmio_host_req host_req = '0;
    logic           afu_rsp_valid = 1'b0;
    t_mmio_afu_rsp  afu_rsp = '0;
    logic           afu_rsp_ready;
    logic           tx_valid;
    t_tx_beat       tx_beat;
    logic           tx_ready = 1'b0;

    // Stimulus and the tx_ready toggling draw from separate streams
    int             stim_seed = SEED;
    int             ready_seed = SEED;
    logic           hold_tx = 1'b0;
    logic           saw_full = 1'b0;
    int             short_cnt = 0;
    int             wide_cnt = 0;

    // Pending requests per function and tag, plus completions still owed per function
    logic           pend [NUM_FUNCS][MAX_TAGS];
    t_mmio_host_req req_model [NUM_FUNCS][MAX_TAGS];
    t_expect        exp_q [NUM_FUNCS][$];
    logic [FUNC_BITS+TAG_BITS-1:0] issued [$];

    mmio_cpl_top #(
        .NUM_FUNCS (NUM_FUNCS),
        .MAX_TAGS  (MAX_TAGS)
    ) mmio_cpl_top_i (
        .clk            (clk),
        .reset_n        (reset_n),
        .host_req_valid (host_req_valid),
        .host_req       (host_req),
        .afu_rsp_valid  (afu_rsp_valid),
        .afu_rsp        (afu_rsp),
        .afu_rsp_ready  (afu_rsp_ready),
        .tx_valid       (tx_valid),
        .tx_beat        (tx_beat),
        .tx_ready       (tx_ready)
    );

    always #2 clk = !clk;

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [255:0] expv, input logic [255:0] actv);
        assert (actv == expv)
        else
        begin
            fail_run($sformatf("ERR %s expected %0h actual %0h", name, expv, actv));
        end
    endtask

    function automatic int outstanding();
        int n;
        n = 0;
        for (int f = 0; f < NUM_FUNCS; f++)
        begin
            n += exp_q[f].size();
        end
        return n;
    endfunction

    // The sink is ready three cycles in four, unless it is held off on purpose
    always @(posedge clk)
    begin
        logic [31:0] r;
        r = $random(ready_seed);
        tx_ready <= reset_n && !hold_tx && (r[1:0] != 2'b00);
    end

    // Beats are checked at the falling edge, before the rising edge that moves them
    always @(negedge clk)
    begin : monitor
        t_expect  e;
        t_cpl_hdr h;
        int       f;
        if (mmio_cpl_top_i.checker_i.error_count != 0)
        begin
            fail_run("A protocol assertion in the bound checker failed");
        end
        if (reset_n && tx_valid && tx_ready)
        begin
            h = tx_beat[0].hdr;
            f = int'(h.completer_id);
            if (f >= NUM_FUNCS || exp_q[f].size() == 0)
            begin
                fail_run("A completion came out that matches no accepted response");
            end
            else
            begin
                // Within one function completions leave in response order
                e = exp_q[f].pop_front();
                compare("header fmttype", 256'(8'h4a), 256'(h.fmttype));
                compare("header tag", 256'(e.req.tag), 256'(h.tag));
                compare("header requester_id", 256'(e.req.requester_id), 256'(h.requester_id));
                compare("header lower_addr", 256'(e.req.lower_addr), 256'(h.lower_addr));
                compare("header byte_count", 256'(e.req.byte_count), 256'(h.byte_count));
                compare("header length", 256'(e.req.byte_count / 4), 256'(h.length));
                compare("lane 0 valid", 256'(1'b1), 256'(tx_beat[0].valid));
                compare("lane 0 payload", e.payload[255:0], tx_beat[0].payload);
                if (e.req.byte_count > 12'd32)
                begin
                    wide_cnt++;
                    compare("wide_read lane 0 eop", 256'(1'b0), 256'(tx_beat[0].eop));
                    compare("wide_read lane 1 valid", 256'(1'b1), 256'(tx_beat[1].valid));
                    compare("wide_read lane 1 eop", 256'(1'b1), 256'(tx_beat[1].eop));
                    compare("wide_read lane 1 payload", e.payload[511:256], tx_beat[1].payload);
                end
                else
                begin
                    short_cnt++;
                    compare("short_read lane 0 eop", 256'(1'b1), 256'(tx_beat[0].eop));
                    compare("short_read lane 1 valid", 256'(1'b0), 256'(tx_beat[1].valid));
                end
            end
        end
    end

    // One strobe per request, on an unused tag of the given function
    task automatic issue_req(input t_func func);
        t_mmio_host_req req;
        logic [31:0]    r;
        logic [31:0]    r2;
        int             tag;
        int             tries;
        r = $random(stim_seed);
        r2 = $random(stim_seed);
        tag = int'(r[TAG_BITS-1:0]);
        tries = 0;
        while (pend[func][tag])
        begin
            tag = (tag + 1) % MAX_TAGS;
            tries++;
            if (tries > MAX_TAGS)
            begin
                fail_run("No free tag was left for a new request");
            end
        end
        req.func = func;
        req.tag = TAG_BITS'(tag);
        req.requester_id = r[31:16];
        req.lower_addr = {r2[8:4], 2'b00};
        // 4 to 64 bytes in whole dwords
        req.byte_count = 12'({r2[3:0], 2'b00}) + 12'd4;
        pend[func][tag] = 1'b1;
        req_model[func][tag] = req;
        issued.push_back({func, req.tag});
        @(posedge clk);
        host_req_valid <= 1'b1;
        host_req <= req;
    endtask

    task automatic send_rsp(input logic [FUNC_BITS+TAG_BITS-1:0] ft);
        t_mmio_afu_rsp rsp;
        t_expect       e;
        int            waited;
        rsp.func = ft[FUNC_BITS+TAG_BITS-1:TAG_BITS];
        rsp.tag = ft[TAG_BITS-1:0];
        for (int k = 0; k < 16; k++)
        begin
            rsp.payload[k*32 +: 32] = $random(stim_seed);
        end
        afu_rsp_valid <= 1'b1;
        afu_rsp <= rsp;
        waited = 0;
        @(negedge clk);
        while (!afu_rsp_ready)
        begin
            waited++;
            if (hold_tx)
            begin
                saw_full <= 1'b1;
            end
            // Let the sink go once the stall has clearly backed up to the port
            if (waited > 16)
            begin
                hold_tx <= 1'b0;
            end
            if (waited > TIMEOUT)
            begin
                fail_run("An accelerator response was never accepted");
            end
            @(negedge clk);
        end
        e.req = req_model[rsp.func][rsp.tag];
        e.payload = rsp.payload;
        exp_q[rsp.func].push_back(e);
        pend[rsp.func][rsp.tag] = 1'b0;
        @(posedge clk);
    endtask

    // Close the request burst, keep the 2-cycle gap, then answer in random order
    task automatic respond_shuffled();
        logic [FUNC_BITS+TAG_BITS-1:0] tmp;
        logic [31:0]                   r;
        int                            j;
        @(posedge clk);
        host_req_valid <= 1'b0;
        repeat (2) @(posedge clk);
        for (int i = issued.size() - 1; i > 0; i--)
        begin
            r = $random(stim_seed);
            j = int'(r[15:0]) % (i + 1);
            tmp = issued[i];
            issued[i] = issued[j];
            issued[j] = tmp;
        end
        while (issued.size() > 0)
        begin
            send_rsp(issued.pop_front());
        end
        afu_rsp_valid <= 1'b0;
    endtask

    task automatic drain_wait();
        int waited;
        waited = 0;
        while (outstanding() != 0)
        begin
            waited++;
            if (waited > TIMEOUT)
            begin
                fail_run("Completions did not drain before the timeout");
            end
            @(negedge clk);
        end
    endtask

    initial
    begin
        logic [31:0] r;
        for (int f = 0; f < NUM_FUNCS; f++)
        begin
            for (int t = 0; t < MAX_TAGS; t++)
            begin
                pend[f][t] = 1'b0;
            end
        end
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        // Mixed functions and sizes with out-of-order responses
        for (int round = 0; round < 4; round++)
        begin
            for (int i = 0; i < 12; i++)
            begin
                r = $random(stim_seed);
                issue_req(r[FUNC_BITS-1:0]);
            end
            respond_shuffled();
            drain_wait();
        end
        // Six responses for one function overrun the arbiter, output register and FIFO
        hold_tx <= 1'b1;
        for (int i = 0; i < 6; i++)
        begin
            issue_req(FUNC_BITS'(1));
        end
        respond_shuffled();
        drain_wait();
        // Idle a little so that a duplicated beat would still show up
        repeat (10) @(posedge clk);
        if (saw_full && short_cnt > 0 && wide_cnt > 0)
        begin
            $display("Simulation finished: PASS");
            $finish;
        end
        else
        begin
            fail_run("Stimulus missed back-pressure or short or wide reads");
        end
    end

endmodule

// ==== src.f ====
mmio_tlp_pkg.sv
mmio_gen_pkg.sv
mmio_func_steer.sv
mmio_cpl_chan.sv
mmio_tx_arb.sv
mmio_cpl_top.sv
mmio_cpl_checker.sv
tb_mmio_cpl.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert --timing -j 0
TOP       ?= tb_mmio_cpl
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
RUN_ARGS  ?= +verilator+error+limit+100

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
